// ==== sim.f ====
game_pkg.sv
shot_pkg.sv
round_if.sv
game_fsm.sv
enemy_pick.sv
round_judge.sv
score_control.sv
penalty_top.sv
tb_penalty.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module tb_penalty -o sim_tb

run: build
	./obj_dir/sim_tb > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing -f sim.f --top-module penalty_top

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_penalty.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_penalty;

    import game_pkg::*;
    import shot_pkg::*;

    // one row per round with start flag, player zone and expected role
    typedef struct packed {
        logic       start;
        logic [3:0] zone;   // 4'hf means take the zone from the LFSR
        logic [1:0] role;
    } row_t;

    localparam int NUM_ROWS = 22;
    localparam logic [3:0] RND = 4'hf;
    localparam logic [1:0] SH = 2'd1;
    localparam logic [1:0] GK = 2'd2;

    // off-target keeper rows make sure each match ends inside its rows
    localparam row_t ROWS [NUM_ROWS] = '{
        '{1'b1, RND,   SH},
        '{1'b0, RND,   GK},
        '{1'b0, RND,   SH},
        '{1'b0, 4'd6,  GK},
        '{1'b0, RND,   SH},
        '{1'b0, 4'd6,  GK},
        '{1'b0, RND,   SH},
        '{1'b0, 4'd7,  GK},
        '{1'b0, RND,   SH},
        '{1'b0, 4'd6,  GK},
        '{1'b0, RND,   SH},
        '{1'b0, 4'd6,  GK},
        '{1'b1, 4'd7,  SH},   // second match opens with a wide shot
        '{1'b0, 4'd6,  GK},
        '{1'b0, 4'd6,  SH},
        '{1'b0, 4'd7,  GK},
        '{1'b0, 4'd0,  SH},
        '{1'b0, 4'd6,  GK},
        '{1'b0, RND,   SH},
        '{1'b0, 4'd6,  GK},
        '{1'b0, RND,   SH},
        '{1'b0, 4'd7,  GK}
    };

    logic       clk = 1'b0;
    logic       rst;
    logic       start;
    logic       kick;
    logic [2:0] zone;
    logic [1:0] game_state;
    logic [2:0] enemy_zone;
    logic       round_done;
    logic       round_scored;
    logic [SCORE_W-1:0] score_player;
    logic [SCORE_W-1:0] score_enemy;
    logic       match_end;
    logic       match_result;

    logic [31:0] lfsr_state;
    int          errors;
    int          tests;
    int          tests_failed;
    int          exp_player;
    int          exp_enemy;
    logic        in_match;
    logic        abort;

    penalty_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .kick         (kick),
        .zone         (zone),
        .game_state   (game_state),
        .enemy_zone   (enemy_zone),
        .round_done   (round_done),
        .round_scored (round_scored),
        .score_player (score_player),
        .score_enemy  (score_enemy),
        .match_end    (match_end),
        .match_result (match_result)
    );

    always #10 clk = ~clk;

    // taps 32 22 2 1 with one step per bit taken
    function automatic logic [31:0] get_rand_bits(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < nbits; b++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic goal_rule(input logic [1:0] role, input logic [2:0] pz,
                                       input logic [2:0] ez);
        if (role == SH) begin
            return (pz < 3'd6) && (pz != ez);   // wide shot is no goal
        end
        return (pz >= 3'd6) || (pz != ez);      // dive nowhere concedes
    endfunction

    task automatic wait_state(input logic [1:0] st, input string what);
        int n;
        n = 0;
        while (game_state !== st && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (game_state !== st) begin
            $display("timeout while waiting for the %s state", what);
            errors++;
            abort = 1'b1;
        end
    endtask

    task automatic start_match();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        wait_state(SH, "shooter");
        check_value("score_player", 32'(score_player), 0);
        check_value("score_enemy", 32'(score_enemy), 0);
        check_value("match_end", 32'(match_end), 0);
        check_value("match_result", 32'(match_result), 0);
        exp_player = 0;
        exp_enemy  = 0;
        in_match   = 1'b1;
    endtask

    task automatic finish_match();
        int n;
        n = 0;
        while (!match_end && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!match_end) begin
            $display("match_end never rose after the winning goal");
            errors++;
            abort = 1'b1;
            return;
        end
        check_value("match_result", 32'(match_result), 32'(exp_player == WIN_SCORE));
        wait_state(OVER, "game over");
        repeat (3) @(negedge clk);
        check_value("score_player", 32'(score_player), 32'(exp_player));
        check_value("score_enemy", 32'(score_enemy), 32'(exp_enemy));
        check_value("match_end", 32'(match_end), 1);
        in_match = 1'b0;
    endtask

    task automatic play_round(input row_t r, input int idx);
        logic [31:0] rnd;
        logic [2:0]  pz;
        logic [2:0]  ez;
        logic        extra;
        logic        seen;
        int          n;
        int          err_before;
        err_before = errors;
        check_value("game_state", 32'(game_state), 32'(r.role));
        if (r.zone == RND) begin
            rnd = get_rand_bits(3);
            pz  = rnd[2:0];
        end else begin
            pz = r.zone[2:0];
        end
        rnd = get_rand_bits(2);
        repeat (rnd) @(posedge clk);
        rnd   = get_rand_bits(1);
        extra = rnd[0];
        @(posedge clk);
        kick <= 1'b1;
        zone <= pz;
        @(posedge clk);
        kick <= 1'b0;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 4 * REVEAL_CYCLES) begin
            @(posedge clk);
            kick <= extra && (n == 1);   // second kick inside the round
            zone <= pz ^ 3'd1;
            @(negedge clk);
            n++;
            seen = round_done;
        end
        if (!seen) begin
            $display("timeout, no round_done after the kick in row %0d", idx);
            errors++;
            abort = 1'b1;
            return;
        end
        check_value("round_done delay", 32'(n), 32'(REVEAL_CYCLES));
        ez = enemy_zone;
        check_value("enemy_zone in range", 32'(ez < NUM_ZONES), 1);
        check_value("round_scored", 32'(round_scored), 32'(goal_rule(r.role, pz, ez)));
        if (goal_rule(r.role, pz, ez)) begin
            if (r.role == SH) exp_player++;
            else exp_enemy++;
        end
        @(negedge clk);
        check_value("score_player", 32'(score_player), 32'(exp_player));
        check_value("score_enemy", 32'(score_enemy), 32'(exp_enemy));
        if (exp_player == WIN_SCORE || exp_enemy == WIN_SCORE) begin
            finish_match();
        end
        tests++;
        if (errors != err_before) tests_failed++;
        $display("row %0d %s zone %0d enemy %0d extra %0b score %0d:%0d %s", idx,
                 (r.role == SH) ? "shooter" : "keeper", pz, ez, extra,
                 exp_player, exp_enemy, (errors == err_before) ? "ok" : "failed");
    endtask

    initial begin
        logic seen;
        rst          = 1'b1;
        start        = 1'b0;
        kick         = 1'b0;
        zone         = 3'd0;
        lfsr_state   = 32'h501135e1;
        errors       = 0;
        tests        = 0;
        tests_failed = 0;
        exp_player   = 0;
        exp_enemy    = 0;
        in_match     = 1'b0;
        abort        = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        // idle ignores kicks
        check_value("game_state", 32'(game_state), 32'(IDLE));
        check_value("score_player", 32'(score_player), 0);
        check_value("score_enemy", 32'(score_enemy), 0);
        check_value("match_end", 32'(match_end), 0);
        @(posedge clk);
        kick <= 1'b1;
        zone <= 3'd2;
        @(posedge clk);
        kick <= 1'b0;
        seen = 1'b0;
        repeat (2 * REVEAL_CYCLES) begin
            @(negedge clk);
            if (round_done) seen = 1'b1;
        end
        if (seen) begin
            $display("round_done pulsed for a kick in the idle state");
            errors++;
        end
        tests++;
        if (errors != 0) tests_failed++;
        $display("idle after reset %s", (errors == 0) ? "ok" : "failed");

        for (int i = 0; i < NUM_ROWS && !abort; i++) begin
            if (ROWS[i].start) begin
                start_match();
            end
            if (in_match && !abort) begin
                play_round(ROWS[i], i);
            end
        end
        if (in_match && !abort) begin
            $display("the table ran out before the match ended");
            errors++;
        end

        $display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
        if (errors == 0 && !abort) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== penalty_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module penalty_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic                        kick,
    input  logic [2:0]                  zone,
    output logic [1:0]                  game_state,
    output logic [2:0]                  enemy_zone,
    output logic                        round_done,
    output logic                        round_scored,
    output logic [game_pkg::SCORE_W-1:0] score_player,
    output logic [game_pkg::SCORE_W-1:0] score_enemy,
    output logic                        match_end,
    output logic                        match_result
);

    import game_pkg::*;
    import shot_pkg::*;

    g_state state_w;
    zone_t  zone_enemy_w;

    round_if if_sh ();
    round_if if_gk ();

    // both judges see the same player inputs
    assign if_sh.kick        = kick;
    assign if_gk.kick        = kick;
    assign if_sh.zone_player = zone;
    assign if_gk.zone_player = zone;
    assign if_sh.zone_enemy  = zone_enemy_w;
    assign if_gk.zone_enemy  = zone_enemy_w;

    game_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .match_end  (match_end),
        .if_sh      (if_sh),
        .if_gk      (if_gk),
        .game_state (state_w)
    );

    enemy_pick u_enemy (
        .clk        (clk),
        .rst        (rst),
        .kick       (kick),
        .zone_enemy (zone_enemy_w)
    );

    round_judge #(.ROLE(SHOOTER)) u_judge_sh (
        .clk (clk),
        .rst (rst),
        .rif (if_sh)
    );

    round_judge #(.ROLE(KEEPER)) u_judge_gk (
        .clk (clk),
        .rst (rst),
        .rif (if_gk)
    );

    score_control u_score (
        .clk          (clk),
        .rst          (rst),
        .game_state   (state_w),
        .start        (start),
        .if_sh        (if_sh),
        .if_gk        (if_gk),
        .match_end    (match_end),
        .match_result (match_result),
        .score_player (score_player),
        .score_enemy  (score_enemy)
    );

    assign game_state = state_w;
    assign enemy_zone = zone_enemy_w;

    // only one judge is active at a time, so OR merges cleanly
    assign round_done   = if_sh.done | if_gk.done;
    assign round_scored = if_sh.scored | if_gk.scored;

endmodule

`default_nettype wire

// ==== score_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_control (
    input  logic                        clk,
    input  logic                        rst,
    input  game_pkg::g_state            game_state,
    input  logic                        start,
    round_if.score                      if_sh,
    round_if.score                      if_gk,
    output logic                        match_end,     // a side has won
    output logic                        match_result,  // 1 when the player won
    output logic [game_pkg::SCORE_W-1:0] score_player,
    output logic [game_pkg::SCORE_W-1:0] score_enemy
);

    import game_pkg::*;

    logic               match_end_nxt;
    logic               match_result_nxt;
    logic [SCORE_W-1:0] score_player_nxt;
    logic [SCORE_W-1:0] score_enemy_nxt;
    logic               clear;
    logic               player_won;
    logic               enemy_won;

    always_ff @(posedge clk) begin
        if (rst) begin
            match_end    <= 1'b0;
            match_result <= 1'b0;
            score_player <= '0;
            score_enemy  <= '0;
        end else begin
            match_end    <= match_end_nxt;
            match_result <= match_result_nxt;
            score_player <= score_player_nxt;
            score_enemy  <= score_enemy_nxt;
        end
    end

    // new match only from the idle or game over screen
    assign clear = start && (game_state == IDLE || game_state == OVER);

    assign player_won = (score_player == SCORE_W'(WIN_SCORE));
    assign enemy_won  = (score_enemy == SCORE_W'(WIN_SCORE));

    always_comb begin
        score_player_nxt = score_player;
        score_enemy_nxt  = score_enemy;
        if (clear) begin
            score_player_nxt = '0;
            score_enemy_nxt  = '0;
        end else if (if_sh.active && if_sh.done && if_sh.scored) begin
            score_player_nxt = score_player + 1'b1;   // player shot went in
        end else if (if_gk.active && if_gk.done && if_gk.scored) begin
            score_enemy_nxt = score_enemy + 1'b1;     // keeper got beaten
        end
    end

    // final score stays in OVER, so the end flags stay up as well
    always_comb begin
        if (clear) begin
            match_end_nxt    = 1'b0;
            match_result_nxt = 1'b0;
        end else begin
            match_end_nxt    = player_won || enemy_won;
            match_result_nxt = player_won;
        end
    end

    a_score_max: assert property (@(posedge clk) disable iff (rst)
        score_player <= WIN_SCORE && score_enemy <= WIN_SCORE);

endmodule

`default_nettype wire

// ==== round_judge.sv ====
`timescale 1ns/1ps
`default_nettype none

module round_judge #(
    parameter game_pkg::g_state ROLE = game_pkg::SHOOTER
) (
    input logic      clk,
    input logic      rst,
    round_if.judge   rif
);

    import game_pkg::*;
    import shot_pkg::*;

    localparam int CNT_W = $clog2(REVEAL_CYCLES + 1);

    logic             busy;     // round being timed
    logic [CNT_W-1:0] cnt;
    logic             done_r;
    logic             accept;
    zone_t            zone_q;   // player zone captured at the kick
    logic             on_target;
    logic             differ;
    logic             goal;

    // the result cycle still counts as part of the round
    assign accept = rif.active & rif.kick & ~busy & ~done_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            cnt    <= '0;
            done_r <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (!rif.active) begin
                busy <= 1'b0;   // role taken away, drop the round
            end else if (accept) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(REVEAL_CYCLES - 1);
            end else if (busy) begin
                if (cnt == '0) begin
                    busy   <= 1'b0;
                    done_r <= 1'b1;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            zone_q <= rif.zone_player;
        end
    end

    assign on_target = (zone_q < NUM_ZONES);
    assign differ    = (zone_q != rif.zone_enemy);

    always_comb begin
        if (ROLE == SHOOTER) begin
            goal = on_target && differ;     // wide shot never scores
        end else begin
            goal = !on_target || differ;    // diving off target concedes
        end
    end

    assign rif.done   = done_r;
    assign rif.scored = done_r & goal;

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        rif.done |=> !rif.done);

    // result only at the end of a timed round
    a_done_timed: assert property (@(posedge clk) disable iff (rst)
        $rose(rif.done) |-> $past(busy && cnt == '0));

endmodule

`default_nettype wire

// ==== enemy_pick.sv ====
`timescale 1ns/1ps
`default_nettype none

module enemy_pick (
    input  logic           clk,
    input  logic           rst,
    input  logic           kick,
    output shot_pkg::zone_t zone_enemy
);

    import shot_pkg::*;

    logic [15:0] lfsr;
    logic        fb;

    // taps 16,14,13,11
    assign fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    // free running, so the pick depends on the kick timing
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= ENEMY_SEED;
        end else begin
            lfsr <= {lfsr[14:0], fb};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            zone_enemy <= '0;
        end else if (kick) begin
            zone_enemy <= zone_t'(lfsr % NUM_ZONES);  // freeze choice for this kick
        end
    end

    a_zone_valid: assert property (@(posedge clk) disable iff (rst)
        zone_enemy < NUM_ZONES);

endmodule

`default_nettype wire

// ==== game_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_fsm (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic            match_end,
    round_if.ctrl           if_sh,
    round_if.ctrl           if_gk,
    output game_pkg::g_state game_state
);

    import game_pkg::*;

    g_state state_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= IDLE;
        end else begin
            game_state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = game_state;
        case (game_state)
            IDLE: begin
                if (start) begin
                    state_nxt = SHOOTER;
                end
            end
            SHOOTER: begin
                if (match_end) begin
                    state_nxt = OVER;   // match decided so leave play
                end else if (if_sh.done) begin
                    state_nxt = KEEPER;
                end
            end
            KEEPER: begin
                if (match_end) begin
                    state_nxt = OVER;
                end else if (if_gk.done) begin
                    state_nxt = SHOOTER;
                end
            end
            OVER: begin
                if (start) begin
                    state_nxt = SHOOTER;  // rematch always opens with a shot
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // only the judge of the current role may time a round
    assign if_sh.active = (game_state == SHOOTER);
    assign if_gk.active = (game_state == KEEPER);

    a_one_active: assert property (@(posedge clk) disable iff (rst)
        !(if_sh.active && if_gk.active));

endmodule

`default_nettype wire

// ==== round_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface round_if;
    import shot_pkg::*;

    logic  active;       // role of this judge is the current state
    logic  kick;         // top level kick strobe
    zone_t zone_player;
    zone_t zone_enemy;   // held enemy choice
    logic  done;         // one cycle result pulse
    logic  scored;       // valid with done

    // round judge side
    modport judge (
        input  active, kick, zone_player, zone_enemy,
        output done, scored
    );

    modport ctrl (output active, input done);  // state machine

    modport score (input active, done, scored);

endinterface

`default_nettype wire

// ==== shot_pkg.sv ====
`default_nettype none

package shot_pkg;

    // 0..5 are the six goal zones, 6 and 7 are off target
    typedef logic [2:0] zone_t;

    localparam int NUM_ZONES = 6;

    // kick edge to result pulse, in clock cycles
    localparam int REVEAL_CYCLES = 4;

    // enemy LFSR start value, must be nonzero
    localparam logic [15:0] ENEMY_SEED = 16'hace1;

endpackage

`default_nettype wire

// ==== game_pkg.sv ====
`default_nettype none

package game_pkg;

    // match flow states, two bits on the top level port
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        SHOOTER = 2'd1,
        KEEPER  = 2'd2,
        OVER    = 2'd3
    } g_state;

    // score counters, enough for 0..WIN_SCORE
    localparam int SCORE_W = 3;

    localparam int WIN_SCORE = 5;  // first side to reach this wins

endpackage

`default_nettype wire
